//--- src/fe_pkg.sv
`default_nettype none

package fe_pkg;

    localparam int VADDR_WIDTH = 32;
    localparam int INSTR_WIDTH = 32;

    localparam logic [VADDR_WIDTH-1:0] BOOT_PC     = 32'h0000_0000;
    localparam logic [VADDR_WIDTH-1:0] TRAP_VECTOR = 32'h0000_0200;

    // major opcode field in instr[6:0]
    localparam logic [6:0] OPCODE_JAL = 7'b1101111;

    typedef enum logic {
        e_fe_fetch     = 1'b0,
        e_fe_exception = 1'b1
    } fe_queue_type_e;

    typedef struct packed {
        logic [VADDR_WIDTH-1:0] pc;
        logic [INSTR_WIDTH-1:0] instr;
    } fe_fetch_s;

    // padded out to the fetch payload width
    typedef struct packed {
        logic [VADDR_WIDTH-1:0] vaddr;
        logic [INSTR_WIDTH-1:0] padding;
    } fe_exception_s;

    typedef union packed {
        fe_fetch_s     fetch;
        fe_exception_s exception;
    } fe_queue_msg_u;

    typedef struct packed {
        fe_queue_type_e msg_type;
        fe_queue_msg_u  msg;
    } fe_queue_s;

    typedef enum logic {
        e_op_state_reset = 1'b0,
        e_op_pc_redirect = 1'b1
    } fe_cmd_opcode_e;

    typedef struct packed {
        fe_cmd_opcode_e         opcode;
        logic [VADDR_WIDTH-1:0] pc;
    } fe_cmd_s;

    typedef struct packed {
        logic [VADDR_WIDTH-1:0] pc;
        logic [INSTR_WIDTH-1:0] instr;
        logic                   exception;
    } retire_s;

endpackage

`default_nettype wire

//--- src/fe_cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module fe_cmd_decode (
    input  wire logic                           clk_i,
    input  wire logic                           reset_i,
    input  wire fe_pkg::fe_cmd_s                fe_cmd_i,
    input  wire logic                           fe_cmd_v_i,
    output logic                                fe_cmd_ready_o,
    output logic                                redirect_v_o,
    output logic [fe_pkg::VADDR_WIDTH-1:0]      redirect_pc_o,
    output logic                                started_o
);
    import fe_pkg::*;

    logic ready_r;
    logic started_r;
    logic cmd_accept;
    logic is_state_reset;

    assign fe_cmd_ready_o = ready_r;
    assign cmd_accept     = fe_cmd_v_i & ready_r;
    assign is_state_reset = (fe_cmd_i.opcode == e_op_state_reset);

    // redirects before the first state reset are ignored
    assign redirect_v_o  = cmd_accept & (is_state_reset | started_r);
    assign redirect_pc_o = fe_cmd_i.pc;
    assign started_o     = started_r;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ready_r   <= 1'b0;
            started_r <= 1'b0;
        end else begin
            ready_r <= 1'b1;
            if (cmd_accept && is_state_reset) begin
                started_r <= 1'b1;
            end
        end
    end

    // back end must drop cmd_v once its command is taken
    redirect_single_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        redirect_v_o |=> !redirect_v_o);

endmodule

`default_nettype wire

//--- src/fe_pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fe_pc_gen (
    input  wire logic                           clk_i,
    input  wire logic                           reset_i,
    input  wire logic                           redirect_v_i,
    input  wire logic [fe_pkg::VADDR_WIDTH-1:0] redirect_pc_i,
    input  wire logic                           started_i,
    output logic [fe_pkg::VADDR_WIDTH-1:0]      imem_req_pc_o,
    output logic                                imem_req_v_o,
    input  wire logic                           imem_req_ready_i,
    input  wire logic [fe_pkg::INSTR_WIDTH-1:0] imem_resp_instr_i,
    input  wire logic                           imem_resp_v_i,
    output fe_pkg::fe_queue_s                   enq_o,
    output logic                                enq_v_o,
    input  wire logic                           fifo_full_i
);
    import fe_pkg::*;

    logic [VADDR_WIDTH-1:0] pc_r;
    logic [VADDR_WIDTH-1:0] hold_pc_r;
    logic                   hold_r;
    logic                   outstanding_r;
    logic                   drop_r;
    logic                   stall_r;

    logic misaligned;
    logic can_fetch;
    logic fetch_enq;
    logic exc_enq;

    assign misaligned = |pc_r[1:0];

    // nothing in flight, room in the queue, no redirect this cycle
    assign can_fetch = started_i & ~stall_r & ~outstanding_r & ~hold_r
                     & ~fifo_full_i & ~redirect_v_i;

    // a request once raised is held until the memory takes it
    assign imem_req_v_o  = hold_r | (can_fetch & ~misaligned);
    assign imem_req_pc_o = hold_r ? hold_pc_r : pc_r;

    assign fetch_enq = imem_resp_v_i & outstanding_r & ~drop_r & ~redirect_v_i;
    assign exc_enq   = can_fetch & misaligned;
    assign enq_v_o   = fetch_enq | exc_enq;

    always_comb begin
        if (exc_enq) begin
            enq_o.msg_type                = e_fe_exception;
            enq_o.msg.exception.vaddr     = pc_r;
            enq_o.msg.exception.padding   = '0;
        end else begin
            enq_o.msg_type                = e_fe_fetch;
            enq_o.msg.fetch.pc            = pc_r;
            enq_o.msg.fetch.instr         = imem_resp_instr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_r          <= BOOT_PC;
            hold_r        <= 1'b0;
            outstanding_r <= 1'b0;
            drop_r        <= 1'b0;
            stall_r       <= 1'b0;
        end else begin
            hold_r <= imem_req_v_o & ~imem_req_ready_i;

            if (imem_req_v_o && imem_req_ready_i) begin
                outstanding_r <= 1'b1;
            end else if (imem_resp_v_i) begin
                outstanding_r <= 1'b0;
            end

            // squash whatever is still held or in flight
            if (redirect_v_i) begin
                drop_r <= hold_r | (outstanding_r & ~imem_resp_v_i);
            end else if (imem_resp_v_i) begin
                drop_r <= 1'b0;
            end

            if (redirect_v_i) begin
                stall_r <= 1'b0;
            end else if (exc_enq) begin
                stall_r <= 1'b1;
            end

            if (redirect_v_i) begin
                pc_r <= redirect_pc_i;
            end else if (fetch_enq) begin
                pc_r <= pc_r + 32'd4;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (imem_req_v_o && !hold_r) begin
            hold_pc_r <= pc_r;
        end
    end

    resp_needs_request: assert property (@(posedge clk_i) disable iff (reset_i)
        imem_resp_v_i |-> outstanding_r);

endmodule

`default_nettype wire

//--- src/fe_queue_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module fe_queue_fifo #(
    parameter int DEPTH = 4
) (
    input  wire logic                  clk_i,
    input  wire logic                  reset_i,
    input  wire logic                  flush_i,
    input  wire fe_pkg::fe_queue_s     enq_i,
    input  wire logic                  enq_v_i,
    output logic                       full_o,
    output fe_pkg::fe_queue_s          deq_o,
    output logic                       deq_v_o,
    input  wire logic                  deq_ready_i
);
    import fe_pkg::*;

    fe_queue_s mem [DEPTH];

    logic [$clog2(DEPTH)-1:0]   wr_ptr_r;
    logic [$clog2(DEPTH)-1:0]   rd_ptr_r;
    logic [$clog2(DEPTH+1)-1:0] count_r;
    logic                       push;
    logic                       pop;

    assign full_o  = (count_r == ($clog2(DEPTH+1))'(DEPTH));
    assign deq_v_o = (count_r != '0);
    assign deq_o   = mem[rd_ptr_r];

    assign push = enq_v_i & ~full_o;
    assign pop  = deq_v_o & deq_ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (push) begin
                wr_ptr_r <= (wr_ptr_r == ($clog2(DEPTH))'(DEPTH-1)) ? '0 : wr_ptr_r + 1'b1;
            end
            if (pop) begin
                rd_ptr_r <= (rd_ptr_r == ($clog2(DEPTH))'(DEPTH-1)) ? '0 : rd_ptr_r + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_r] <= enq_i;
        end
    end

    // pc_gen checks full before it fetches
    no_enq_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
        enq_v_i |-> !full_o);

endmodule

`default_nettype wire

//--- src/be_branch_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module be_branch_resolve (
    input  wire logic                  clk_i,
    input  wire logic                  reset_i,
    input  wire fe_pkg::fe_queue_s     fe_queue_i,
    input  wire logic                  fe_queue_v_i,
    output logic                       fe_queue_ready_o,
    output fe_pkg::fe_cmd_s            fe_cmd_o,
    output logic                       fe_cmd_v_o,
    input  wire logic                  fe_cmd_ready_i,
    output fe_pkg::retire_s            retire_o,
    output logic                       retire_v_o
);
    import fe_pkg::*;

    logic    boot_r;
    logic    cmd_v_r;
    fe_cmd_s cmd_r;
    logic    retire_v_r;
    retire_s retire_r;

    logic                   accept;
    logic                   is_exc;
    logic                   is_jal;
    logic [VADDR_WIDTH-1:0] msg_pc;
    logic [INSTR_WIDTH-1:0] msg_instr;
    logic [VADDR_WIDTH-1:0] jal_imm;
    logic [VADDR_WIDTH-1:0] jal_target;

    // no messages taken while a command waits
    assign fe_queue_ready_o = ~cmd_v_r & ~boot_r;
    assign accept           = fe_queue_v_i & fe_queue_ready_o;

    assign is_exc = (fe_queue_i.msg_type == e_fe_exception);

    // exception vaddr overlays the fetch pc
    assign msg_pc = fe_queue_i.msg.fetch.pc;

    always_comb begin
        if (is_exc) begin
            msg_instr = '0;
        end else begin
            msg_instr = fe_queue_i.msg.fetch.instr;
        end
    end

    assign is_jal = ~is_exc & (msg_instr[6:0] == OPCODE_JAL);

    // sign extended j-type immediate
    assign jal_imm = {{11{msg_instr[31]}}, msg_instr[31], msg_instr[19:12],
                      msg_instr[20], msg_instr[30:21], 1'b0};
    assign jal_target = msg_pc + jal_imm;

    assign fe_cmd_o   = cmd_r;
    assign fe_cmd_v_o = cmd_v_r;
    assign retire_o   = retire_r;
    assign retire_v_o = retire_v_r;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            boot_r     <= 1'b1;
            cmd_v_r    <= 1'b0;
            retire_v_r <= 1'b0;
        end else begin
            retire_v_r <= accept;
            if (boot_r) begin
                boot_r  <= 1'b0;
                cmd_v_r <= 1'b1;
            end else if (cmd_v_r && fe_cmd_ready_i) begin
                cmd_v_r <= 1'b0;
            end else if (accept && (is_exc || is_jal)) begin
                cmd_v_r <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (boot_r) begin
            cmd_r.opcode <= e_op_state_reset;
            cmd_r.pc     <= BOOT_PC;
        end else if (accept && (is_exc || is_jal)) begin
            cmd_r.opcode <= e_op_pc_redirect;
            cmd_r.pc     <= is_exc ? TRAP_VECTOR : jal_target;
        end
        if (accept) begin
            retire_r.pc        <= msg_pc;
            retire_r.instr     <= msg_instr;
            retire_r.exception <= is_exc;
        end
    end

    cmd_held_until_taken: assert property (@(posedge clk_i) disable iff (reset_i)
        fe_cmd_v_o && !fe_cmd_ready_i |=> fe_cmd_v_o && $stable(fe_cmd_o));

endmodule

`default_nettype wire

//--- src/fe_be_top.sv
`timescale 1ns/1ps
`default_nettype none

module fe_be_top (
    input  wire logic                           clk_i,
    input  wire logic                           reset_i,
    output logic [fe_pkg::VADDR_WIDTH-1:0]      imem_req_pc_o,
    output logic                                imem_req_v_o,
    input  wire logic                           imem_req_ready_i,
    input  wire logic [fe_pkg::INSTR_WIDTH-1:0] imem_resp_instr_i,
    input  wire logic                           imem_resp_v_i,
    output fe_pkg::retire_s                     retire_o,
    output logic                                retire_v_o
);
    import fe_pkg::*;

    fe_cmd_s                fe_cmd;
    logic                   cmd_v;
    logic                   cmd_ready;
    logic                   redirect_v;
    logic [VADDR_WIDTH-1:0] redirect_pc;
    logic                   started;
    fe_queue_s              enq;
    logic                   enq_v;
    logic                   fifo_full;
    fe_queue_s              fe_queue;
    logic                   queue_v;
    logic                   queue_ready;

    fe_cmd_decode u_cmd_decode (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .fe_cmd_i       (fe_cmd),
        .fe_cmd_v_i     (cmd_v),
        .fe_cmd_ready_o (cmd_ready),
        .redirect_v_o   (redirect_v),
        .redirect_pc_o  (redirect_pc),
        .started_o      (started)
    );

    fe_pc_gen u_pc_gen (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .redirect_v_i      (redirect_v),
        .redirect_pc_i     (redirect_pc),
        .started_i         (started),
        .imem_req_pc_o     (imem_req_pc_o),
        .imem_req_v_o      (imem_req_v_o),
        .imem_req_ready_i  (imem_req_ready_i),
        .imem_resp_instr_i (imem_resp_instr_i),
        .imem_resp_v_i     (imem_resp_v_i),
        .enq_o             (enq),
        .enq_v_o           (enq_v),
        .fifo_full_i       (fifo_full)
    );

    // redirect flushes anything queued for the old path
    fe_queue_fifo #(
        .DEPTH (4)
    ) u_queue_fifo (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .flush_i     (redirect_v),
        .enq_i       (enq),
        .enq_v_i     (enq_v),
        .full_o      (fifo_full),
        .deq_o       (fe_queue),
        .deq_v_o     (queue_v),
        .deq_ready_i (queue_ready)
    );

    be_branch_resolve u_branch_resolve (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .fe_queue_i       (fe_queue),
        .fe_queue_v_i     (queue_v),
        .fe_queue_ready_o (queue_ready),
        .fe_cmd_o         (fe_cmd),
        .fe_cmd_v_o       (cmd_v),
        .fe_cmd_ready_i   (cmd_ready),
        .retire_o         (retire_o),
        .retire_v_o       (retire_v_o)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // released just after an edge like the other inputs
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 reset_o = 1'b0;
    end

endmodule

`default_nettype wire

//--- bench/fe_be_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fe_be_tb;
    import fe_pkg::*;

    localparam int PAT_WORDS     = 128;
    localparam int MEM_WORDS     = 256;
    localparam int MAX_EXPECT    = 64;
    localparam int RESET_TIMEOUT = 50;
    localparam int RUN_TIMEOUT   = 2000;
    localparam logic [31:0] END_MARK  = 32'hffff_ffff;
    localparam logic [31:0] LFSR_SEED = 32'h08dd_1403;

    logic                   clk;
    logic                   reset;
    logic                   imem_req_ready;
    logic [INSTR_WIDTH-1:0] imem_resp_instr;
    logic                   imem_resp_v;
    logic [VADDR_WIDTH-1:0] imem_req_pc;
    logic                   imem_req_v;
    retire_s                retire;
    logic                   retire_v;

    logic [31:0] pat [PAT_WORDS];
    logic [31:0] imem [MEM_WORDS];
    logic [31:0] exp_pc [MAX_EXPECT];
    logic [31:0] exp_instr [MAX_EXPECT];
    logic        exp_exc [MAX_EXPECT];
    int          exp_count;
    int          exp_idx;
    int          errors;
    logic [31:0] lfsr;

    tb_clock_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (10)
    ) u_clock_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    fe_be_top UUT (
        .clk_i             (clk),
        .reset_i           (reset),
        .imem_req_pc_o     (imem_req_pc),
        .imem_req_v_o      (imem_req_v),
        .imem_req_ready_i  (imem_req_ready),
        .imem_resp_instr_i (imem_resp_instr),
        .imem_resp_v_i     (imem_resp_v),
        .retire_o          (retire),
        .retire_v_o        (retire_v)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_bits(input int n, output logic [3:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[2:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic load_patterns();
        int i;
        int p;
        int n;
        for (i = 0; i < PAT_WORDS; i++) begin
            pat[i] = END_MARK;
        end
        $readmemh("bench/fe_be_patterns.txt", pat);
        // unlisted words are addi x0, x0, addr
        for (i = 0; i < MEM_WORDS; i++) begin
            imem[i] = {12'(i * 4), 20'h00013};
        end
        p = 0;
        while (p + 1 < PAT_WORDS && pat[p] !== END_MARK) begin
            imem[pat[p][9:2]] = pat[p + 1];
            p += 2;
        end
        p++;
        n = 0;
        while (p + 2 < PAT_WORDS && pat[p] !== END_MARK && n < MAX_EXPECT) begin
            exp_pc[n]    = pat[p];
            exp_instr[n] = pat[p + 1];
            exp_exc[n]   = pat[p + 2][0];
            n++;
            p += 3;
        end
        exp_count = n;
    endtask

    // one request in flight with 0 to 3 extra cycles of latency
    initial begin : imem_model
        logic        busy;
        logic [1:0]  wait_left;
        logic [31:0] pend_addr;
        logic        req_fire;
        logic [31:0] req_addr;
        logic [3:0]  bits;
        logic        held;
        logic [31:0] held_addr;
        busy      = 1'b0;
        wait_left = '0;
        pend_addr = '0;
        held      = 1'b0;
        held_addr = '0;
        forever begin
            @(negedge clk);
            // requests only go out for word aligned pcs
            if (reset === 1'b0 && imem_req_v === 1'b1) begin
                check_value("imem_req_pc_o[1:0]", {30'b0, imem_req_pc[1:0]}, 32'h0);
            end
            // a request not taken is offered again unchanged
            if (held) begin
                check_value("imem_req_v_o", {31'b0, imem_req_v}, 32'h1);
                check_value("imem_req_pc_o", imem_req_pc, held_addr);
            end
            held      = (reset === 1'b0) && (imem_req_v === 1'b1) && (imem_req_ready === 1'b0);
            held_addr = imem_req_pc;
            req_fire = (reset === 1'b0) && (imem_req_v === 1'b1) && (imem_req_ready === 1'b1);
            req_addr = imem_req_pc;
            @(posedge clk);
            #1;
            if (imem_resp_v) begin
                imem_resp_v = 1'b0;
                busy        = 1'b0;
            end
            if (req_fire) begin
                busy      = 1'b1;
                pend_addr = req_addr;
                random_bits(2, bits);
                wait_left = bits[1:0];
            end else if (busy && wait_left != 0) begin
                wait_left = wait_left - 2'd1;
            end
            if (busy && wait_left == 0) begin
                imem_resp_v     = 1'b1;
                imem_resp_instr = imem[pend_addr[9:2]];
            end
            random_bits(1, bits);
            imem_req_ready = !busy && bits[0];
        end
    end

    // retires past the end of the list are not checked
    always @(negedge clk) begin
        if (reset === 1'b0 && retire_v === 1'b1 && exp_idx < exp_count) begin
            check_value("retire_o.pc", retire.pc, exp_pc[exp_idx]);
            check_value("retire_o.instr", retire.instr, exp_instr[exp_idx]);
            check_value("retire_o.exception", {31'b0, retire.exception},
                        {31'b0, exp_exc[exp_idx]});
            exp_idx++;
        end
    end

    initial begin
        int cycles;
        imem_req_ready  = 1'b0;
        imem_resp_v     = 1'b0;
        imem_resp_instr = '0;
        errors          = 0;
        exp_idx         = 0;
        exp_count       = 0;
        lfsr            = LFSR_SEED;
        load_patterns();
        if (exp_count == 0) begin
            $display("no expected retires found in the pattern file");
            errors++;
        end
        cycles = 0;
        while (reset !== 1'b0 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (reset !== 1'b0) begin
            $display("reset was never released");
            errors++;
        end else begin
            @(negedge clk);
            check_value("imem_req_v_o", {31'b0, imem_req_v}, 32'h0);
            check_value("retire_v_o", {31'b0, retire_v}, 32'h0);
            cycles = 0;
            while (exp_idx < exp_count && cycles < RUN_TIMEOUT) begin
                @(posedge clk);
                cycles++;
            end
            if (exp_idx < exp_count) begin
                $display("timeout after %0d cycles with %0d of %0d retires seen",
                         cycles, exp_idx, exp_count);
                errors++;
            end
        end
        $display("errors: %0d, retires checked: %0d of %0d", errors, exp_idx, exp_count);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fe_be_top.f
src/fe_pkg.sv
src/fe_cmd_decode.sv
src/fe_pc_gen.sv
src/fe_queue_fifo.sv
src/be_branch_resolve.sv
src/fe_be_top.sv
bench/tb_clock_gen.sv
bench/fe_be_tb.sv

//--- Makefile
BUILD := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f fe_be_top.f \
		--top-module fe_be_tb -Mdir $(BUILD) -o fe_be_sim
	@out="$$(./$(BUILD)/fe_be_sim)"; echo "$$out"; \
		echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf $(BUILD)

//--- bench/fe_be_patterns.txt
// memory lines: address instruction, closed by ffffffff
// expected retires: pc instruction exception, closed by ffffffff
0000000c 0340006f
00000044 03c0006f
00000084 fedff06f
00000074 fedff06f
00000064 05c0006f
000000c4 00e0006f
ffffffff
// boot, then straight line code up to the first jal
00000000 00000013 0
00000004 00400013 0
00000008 00800013 0
0000000c 0340006f 0
00000040 04000013 0
00000044 03c0006f 0
// two backward jumps, then a forward jump out
00000080 08000013 0
00000084 fedff06f 0
00000070 07000013 0
00000074 fedff06f 0
00000060 06000013 0
00000064 05c0006f 0
// jal to a misaligned target, then the trap vector
000000c0 0c000013 0
000000c4 00e0006f 0
000000d2 00000000 1
00000200 20000013 0
00000204 20400013 0
00000208 20800013 0
ffffffff
